// ==== hw/accel_pkg.sv ====
package accel_pkg;

  // Memory and block geometry
  localparam int WORD_W      = 32;
  localparam int ADDR_W      = 16;
  localparam int BLOCK_WORDS = 4;
  localparam int BLOCK_W     = WORD_W * BLOCK_WORDS;
  localparam int BLOCK_BYTES = BLOCK_W / 8;
  localparam int WORD_IDX_W  = $clog2(BLOCK_WORDS);

  // Job and round sizing
  localparam int NUM_ROUNDS = 4;
  localparam int ROUND_W    = $clog2(NUM_ROUNDS + 1);
  localparam int CNT_W      = 8;

  // Credits granted on each block stream and on the write port
  localparam int STREAM_CREDITS = 2;
  localparam int CRED_W         = $clog2(STREAM_CREDITS + 1);
  localparam int PTR_W          = $clog2(STREAM_CREDITS);

  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_STARTING,
    ACC_WORKING,
    ACC_FINISHED
  } accel_state_t;

  // Word i holds bytes 4i..4i+3, lowest byte at the low bits.
  // Byte 4c+r is row r, column c of the state matrix.
  typedef union packed {
    logic [BLOCK_WORDS-1:0][WORD_W-1:0] words;
    logic [BLOCK_BYTES-1:0][7:0]        bytes;
  } block_t;

endpackage

// ==== hw/block_stream_if.sv ====
interface block_stream_if import accel_pkg::*; ();

  logic   valid;
  block_t data;
  // One pulse per freed buffer slot
  logic   credit;

  modport tx (
    output valid,
    output data,
    input  credit
  );

  modport rx (
    input  valid,
    input  data,
    output credit
  );

endinterface

// ==== hw/accel_fsm.sv ====
module accel_fsm import accel_pkg::*; (
  input  logic clk,
  input  logic reset_n,
  input  logic start_i,
  input  logic job_done_i,
  output logic job_start_o,
  output logic busy_o,
  output logic done_o
);

  accel_state_t state_q;
  accel_state_t state_d;

  always_ff @(posedge clk or negedge reset_n) begin : state_seq
    if (!reset_n) begin
      state_q <= ACC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin : next_state_comb
    state_d = state_q;
    case (state_q)
      ACC_IDLE: begin
        if (start_i) begin
          state_d = ACC_STARTING;
        end
      end
      // Single setup cycle
      ACC_STARTING: begin
        state_d = ACC_WORKING;
      end
      ACC_WORKING: begin
        if (job_done_i) begin
          state_d = ACC_FINISHED;
        end
      end
      ACC_FINISHED: begin
        state_d = ACC_IDLE;
      end
      default: begin
        state_d = ACC_IDLE;
      end
    endcase
  end

  always_comb begin : output_comb
    job_start_o = 1'b0;
    busy_o      = 1'b0;
    done_o      = 1'b0;
    case (state_q)
      // Units latch the job inputs in the same cycle start_i is seen
      ACC_IDLE:                  job_start_o = start_i;
      ACC_STARTING, ACC_WORKING: busy_o      = 1'b1;
      ACC_FINISHED:              done_o      = 1'b1;
      default:                   busy_o      = 1'b0;
    endcase
  end

endmodule

// ==== hw/plaintext_source.sv ====
module plaintext_source import accel_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              job_start_i,
  input  logic [ADDR_W-1:0] src_addr_i,
  input  logic [CNT_W-1:0]  num_blocks_i,
  output logic              rd_req_o,
  output logic [ADDR_W-1:0] rd_addr_o,
  input  logic              rd_valid_i,
  input  logic [WORD_W-1:0] rd_data_i,
  block_stream_if.tx        out_o
);

  logic [ADDR_W-1:0]     addr_q;
  logic [CNT_W-1:0]      blocks_left_q;
  logic [WORD_IDX_W-1:0] word_idx_q;
  logic                  pending_q;
  logic                  full_q;
  logic [CRED_W-1:0]     credits_q;
  block_t                blk_q;
  logic                  send;

  // Reads only start while a stream credit is held, so a stalled engine stops fetching
  assign rd_req_o = (blocks_left_q != '0) && !pending_q && !full_q && (credits_q != '0);
  assign rd_addr_o = addr_q;

  assign send        = full_q && (credits_q != '0);
  assign out_o.valid = send;
  assign out_o.data  = blk_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      addr_q        <= '0;
      blocks_left_q <= '0;
      word_idx_q    <= '0;
      pending_q     <= 1'b0;
      full_q        <= 1'b0;
      credits_q     <= CRED_W'(STREAM_CREDITS);
    end else begin
      if (job_start_i) begin
        addr_q        <= src_addr_i;
        blocks_left_q <= num_blocks_i;
        word_idx_q    <= '0;
      end else if (rd_req_o) begin
        addr_q    <= addr_q + 1'b1;
        pending_q <= 1'b1;
      end else if (rd_valid_i) begin
        pending_q  <= 1'b0;
        word_idx_q <= word_idx_q + 1'b1;
        // Last word completes the block
        if (word_idx_q == WORD_IDX_W'(BLOCK_WORDS - 1)) begin
          full_q        <= 1'b1;
          blocks_left_q <= blocks_left_q - 1'b1;
        end
      end
      if (send) begin
        full_q <= 1'b0;
      end
      credits_q <= credits_q - CRED_W'(send) + CRED_W'(out_o.credit);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid_i) begin
      blk_q.words[word_idx_q] <= rd_data_i;
    end
  end

endmodule

// ==== hw/round_key_gen.sv ====
module round_key_gen import accel_pkg::*; (
  input  logic   clk,
  input  logic   reset_n,
  input  logic   job_start_i,
  input  block_t key_i,
  input  logic   key_step_i,
  input  logic   key_rewind_i,
  output block_t round_key_o
);

  block_t             key0_q;
  block_t             key_q;
  block_t             key_next;
  logic [ROUND_W-1:0] round_q;

  // Rotate left by one byte, then fold the round constant into the top byte
  always_comb begin
    for (int b = 0; b < BLOCK_BYTES; b++) begin
      key_next.bytes[b] = key_q.bytes[(b + BLOCK_BYTES - 1) % BLOCK_BYTES];
    end
    key_next.bytes[BLOCK_BYTES-1] = key_next.bytes[BLOCK_BYTES-1] ^ (8'h01 << round_q);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      round_q <= '0;
    end else if (job_start_i || key_rewind_i) begin
      round_q <= '0;
    end else if (key_step_i) begin
      round_q <= round_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (job_start_i) begin
      key0_q <= key_i;
      key_q  <= key_i;
    end else if (key_rewind_i) begin
      key_q <= key0_q;
    end else if (key_step_i) begin
      key_q <= key_next;
    end
  end

  assign round_key_o = key_q;

endmodule

// ==== hw/round_engine.sv ====
module round_engine import accel_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  block_stream_if.rx in_i,
  input  block_t     round_key_i,
  output logic       key_step_o,
  output logic       key_rewind_o,
  block_stream_if.tx out_o
);

  block_t             fifo_q [STREAM_CREDITS];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CRED_W-1:0]  count_q;
  logic [CRED_W-1:0]  credits_q;
  logic               active_q;
  logic [ROUND_W-1:0] rnd_q;
  block_t             work_q;
  block_t             round_in;
  logic               load;
  logic               rounds_done;
  logic               send;

  // ShiftRows moves (r,c) from (r,(c+r) mod 4), then AddRoundKey
  function automatic block_t apply_round(block_t state, block_t key);
    block_t res;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        res.bytes[4*c+r] = state.bytes[4*((c+r)%4)+r] ^ key.bytes[4*c+r];
      end
    end
    return res;
  endfunction

  assign rounds_done = active_q && (rnd_q == ROUND_W'(NUM_ROUNDS));
  assign load        = !active_q && (count_q != '0);
  assign send        = rounds_done && (credits_q != '0);

  // Slot is freed as soon as its block moves into the working register
  assign in_i.credit  = load;
  assign out_o.valid  = send;
  assign out_o.data   = work_q;
  assign key_step_o   = load || (active_q && !rounds_done);
  assign key_rewind_o = send;

  // First round is applied on load
  assign round_in = load ? fifo_q[rd_ptr_q] : work_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      credits_q <= CRED_W'(STREAM_CREDITS);
      active_q  <= 1'b0;
      rnd_q     <= '0;
    end else begin
      if (in_i.valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        active_q <= 1'b1;
        rnd_q    <= ROUND_W'(1);
      end else if (send) begin
        active_q <= 1'b0;
      end else if (key_step_o) begin
        rnd_q <= rnd_q + 1'b1;
      end
      count_q   <= count_q + CRED_W'(in_i.valid) - CRED_W'(load);
      credits_q <= credits_q - CRED_W'(send) + CRED_W'(out_o.credit);
    end
  end

  always_ff @(posedge clk) begin
    if (in_i.valid) begin
      fifo_q[wr_ptr_q] <= in_i.data;
    end
    if (key_step_o) begin
      work_q <= apply_round(round_in, round_key_i);
    end
  end

endmodule

// ==== hw/ciphertext_sink.sv ====
module ciphertext_sink import accel_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              job_start_i,
  input  logic [ADDR_W-1:0] dst_addr_i,
  input  logic [CNT_W-1:0]  num_blocks_i,
  block_stream_if.rx        in_i,
  output logic              wr_valid_o,
  output logic [ADDR_W-1:0] wr_addr_o,
  output logic [WORD_W-1:0] wr_data_o,
  input  logic              wr_credit_i,
  output logic              job_done_o
);

  block_t                slot_q [STREAM_CREDITS];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CRED_W-1:0]     count_q;
  logic [CRED_W-1:0]     wr_credits_q;
  logic [ADDR_W-1:0]     addr_q;
  logic [CNT_W-1:0]      blocks_left_q;
  logic [WORD_IDX_W-1:0] word_idx_q;
  logic                  issue;
  logic                  last_word;

  // One word per cycle while a block is buffered and a write credit is held
  assign issue     = (count_q != '0) && (wr_credits_q != '0) && (blocks_left_q != '0);
  assign last_word = (word_idx_q == WORD_IDX_W'(BLOCK_WORDS - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      wr_credits_q  <= CRED_W'(STREAM_CREDITS);
      addr_q        <= '0;
      blocks_left_q <= '0;
      word_idx_q    <= '0;
      wr_valid_o    <= 1'b0;
      in_i.credit   <= 1'b0;
      job_done_o    <= 1'b0;
    end else begin
      wr_valid_o  <= issue;
      in_i.credit <= issue && last_word;
      // Lines up with the final wr_valid_o of the job
      job_done_o  <= issue && last_word && (blocks_left_q == CNT_W'(1));
      if (in_i.valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      count_q      <= count_q + CRED_W'(in_i.valid) - CRED_W'(issue && last_word);
      wr_credits_q <= wr_credits_q - CRED_W'(issue) + CRED_W'(wr_credit_i);
      if (job_start_i) begin
        addr_q        <= dst_addr_i;
        blocks_left_q <= num_blocks_i;
        word_idx_q    <= '0;
      end else if (issue) begin
        addr_q     <= addr_q + 1'b1;
        word_idx_q <= word_idx_q + 1'b1;
        if (last_word) begin
          rd_ptr_q      <= rd_ptr_q + 1'b1;
          blocks_left_q <= blocks_left_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_i.valid) begin
      slot_q[wr_ptr_q] <= in_i.data;
    end
    if (issue) begin
      wr_addr_o <= addr_q;
      wr_data_o <= slot_q[rd_ptr_q].words[word_idx_q];
    end
  end

endmodule

// ==== hw/accel_top.sv ====
module accel_top import accel_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  // Job setup
  input  logic               start_i,
  input  logic [ADDR_W-1:0]  src_addr_i,
  input  logic [ADDR_W-1:0]  dst_addr_i,
  input  logic [CNT_W-1:0]   num_blocks_i,
  input  logic [BLOCK_W-1:0] key_i,
  output logic               busy_o,
  output logic               done_o,
  // Memory read port
  output logic               rd_req_o,
  output logic [ADDR_W-1:0]  rd_addr_o,
  input  logic               rd_valid_i,
  input  logic [WORD_W-1:0]  rd_data_i,
  // Memory write port
  output logic               wr_valid_o,
  output logic [ADDR_W-1:0]  wr_addr_o,
  output logic [WORD_W-1:0]  wr_data_o,
  input  logic               wr_credit_i
);

  logic   job_start;
  logic   job_done;
  logic   key_step;
  logic   key_rewind;
  block_t round_key;

  block_stream_if src_stream ();
  block_stream_if res_stream ();

  accel_fsm accel_fsm_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (start_i),
    .job_done_i  (job_done),
    .job_start_o (job_start),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  plaintext_source plaintext_source_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .job_start_i  (job_start),
    .src_addr_i   (src_addr_i),
    .num_blocks_i (num_blocks_i),
    .rd_req_o     (rd_req_o),
    .rd_addr_o    (rd_addr_o),
    .rd_valid_i   (rd_valid_i),
    .rd_data_i    (rd_data_i),
    .out_o        (src_stream.tx)
  );

  round_key_gen round_key_gen_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .job_start_i  (job_start),
    .key_i        (key_i),
    .key_step_i   (key_step),
    .key_rewind_i (key_rewind),
    .round_key_o  (round_key)
  );

  round_engine round_engine_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .in_i         (src_stream.rx),
    .round_key_i  (round_key),
    .key_step_o   (key_step),
    .key_rewind_o (key_rewind),
    .out_o        (res_stream.tx)
  );

  ciphertext_sink ciphertext_sink_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .job_start_i  (job_start),
    .dst_addr_i   (dst_addr_i),
    .num_blocks_i (num_blocks_i),
    .in_i         (res_stream.rx),
    .wr_valid_o   (wr_valid_o),
    .wr_addr_o    (wr_addr_o),
    .wr_data_o    (wr_data_o),
    .wr_credit_i  (wr_credit_i),
    .job_done_o   (job_done)
  );

endmodule

// ==== verification/accel_tb.sv ====
module accel_tb import accel_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [BLOCK_W-1:0] key;
    logic [CNT_W-1:0]   blocks;
    logic [ADDR_W-1:0]  src;
    logic [ADDR_W-1:0]  dst;
    logic               slow_credits;
  } job_cfg_t;

  logic               clk = 1'b0;
  logic               reset_n;
  logic               start;
  logic [ADDR_W-1:0]  src_addr;
  logic [ADDR_W-1:0]  dst_addr;
  logic [CNT_W-1:0]   num_blocks;
  logic [BLOCK_W-1:0] key;
  logic               busy;
  logic               done;
  logic               rd_req;
  logic [ADDR_W-1:0]  rd_addr;
  logic               rd_valid;
  logic [WORD_W-1:0]  rd_data;
  logic               wr_valid;
  logic [ADDR_W-1:0]  wr_addr;
  logic [WORD_W-1:0]  wr_data;
  logic               wr_credit;

  // Job table
  job_cfg_t jobs [$];
  string    names [$];
  string    cur_name;

  // Memory model state
  logic [WORD_W-1:0] mem [2**ADDR_W];
  logic [31:0]       lfsr_q = 32'h54a6;
  int                rd_wait;
  logic [ADDR_W-1:0] rd_addr_q;
  int                credit_due [$];
  int                model_cycle;
  int                writes_out;
  int                wr_count;
  logic [ADDR_W-1:0] wr_next_addr;
  logic              slow_credits;

  int error_count;
  int check_count;
  int limit_cycles;

  accel_top accel_top_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (start),
    .src_addr_i   (src_addr),
    .dst_addr_i   (dst_addr),
    .num_blocks_i (num_blocks),
    .key_i        (key),
    .busy_o       (busy),
    .done_o       (done),
    .rd_req_o     (rd_req),
    .rd_addr_o    (rd_addr),
    .rd_valid_i   (rd_valid),
    .rd_data_i    (rd_data),
    .wr_valid_o   (wr_valid),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .wr_credit_i  (wr_credit)
  );

  always #2 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic int draw_bits(int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // Next round key is the key rotated up by one byte with the constant in the top byte
  function automatic logic [BLOCK_W-1:0] key_after(logic [BLOCK_W-1:0] k, int idx);
    logic [BLOCK_W-1:0] nk;
    nk = {k[BLOCK_W-9:0], k[BLOCK_W-1 -: 8]};
    nk[BLOCK_W-1 -: 8] = nk[BLOCK_W-1 -: 8] ^ (8'h01 << idx);
    return nk;
  endfunction

  function automatic logic [BLOCK_W-1:0] transform(logic [BLOCK_W-1:0] pt,
                                                   logic [BLOCK_W-1:0] job_key);
    logic [BLOCK_W-1:0] st;
    logic [BLOCK_W-1:0] sh;
    logic [BLOCK_W-1:0] k;
    st = pt;
    k  = job_key;
    for (int rnd = 0; rnd < NUM_ROUNDS; rnd++) begin
      // Row r of column c comes from column (c+r) mod 4
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
          sh[8*(4*c+r) +: 8] = st[8*(4*((c+r)%4)+r) +: 8];
        end
      end
      st = sh ^ k;
      k  = key_after(k, rnd);
    end
    return st;
  endfunction

  task automatic check_value(string what, logic [WORD_W-1:0] exp, logic [WORD_W-1:0] act);
    check_count++;
    assert (act === exp) else begin
      error_count++;
      $display("ERROR %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_true(logic cond, string msg);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("%s: %s", cur_name, msg);
    end
  endtask

  task automatic add_job(string name, logic [BLOCK_W-1:0] job_key, int blocks,
                         logic [ADDR_W-1:0] src, logic [ADDR_W-1:0] dst, logic slow);
    job_cfg_t cfg;
    cfg.key          = job_key;
    cfg.blocks       = CNT_W'(blocks);
    cfg.src          = src;
    cfg.dst          = dst;
    cfg.slow_credits = slow;
    names.push_back(name);
    jobs.push_back(cfg);
    limit_cycles += blocks * 40;
  endtask

  // Reads return after 1 to 3 cycles and write credits after a random delay
  always @(posedge clk) begin : memory_model
    int d;
    #1;
    rd_valid  = 1'b0;
    wr_credit = 1'b0;
    if (rd_req) begin
      d         = draw_bits(2);
      rd_wait   = 1 + d % 3;
      rd_addr_q = rd_addr;
    end else if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        rd_valid = 1'b1;
        rd_data  = mem[rd_addr_q];
      end
    end
    if (wr_valid) begin
      check_value("write address", WORD_W'(wr_next_addr), WORD_W'(wr_addr));
      mem[wr_addr] = wr_data;
      wr_next_addr = wr_next_addr + ADDR_W'(1);
      wr_count++;
      writes_out++;
      check_true(writes_out <= STREAM_CREDITS,
                 "more writes in flight than write credits granted");
      if (slow_credits) begin
        d = draw_bits(3) + 6;
      end else begin
        d = draw_bits(1) + 1;
      end
      credit_due.push_back(model_cycle + d);
    end
    if (credit_due.size() > 0 && credit_due[0] <= model_cycle) begin
      void'(credit_due.pop_front());
      wr_credit = 1'b1;
      writes_out--;
    end
    model_cycle++;
  end

  task automatic run_job(int j);
    job_cfg_t           cfg;
    int                 val;
    int                 done_seen;
    logic               last_wr;
    logic [BLOCK_W-1:0] pt;
    logic [BLOCK_W-1:0] exp;
    cfg      = jobs[j];
    cur_name = names[j];
    for (int a = 0; a < int'(cfg.blocks) * BLOCK_WORDS; a++) begin
      val = draw_bits(32);
      mem[cfg.src + ADDR_W'(a)] = WORD_W'(val);
    end
    wr_count     = 0;
    wr_next_addr = cfg.dst;
    slow_credits = cfg.slow_credits;
    @(posedge clk);
    #1;
    check_value("busy_o before start", 0, WORD_W'(busy));
    start      = 1'b1;
    src_addr   = cfg.src;
    dst_addr   = cfg.dst;
    num_blocks = cfg.blocks;
    key        = cfg.key;
    @(posedge clk);
    #1;
    start = 1'b0;
    check_value("busy_o after start", 1, WORD_W'(busy));
    done_seen = 0;
    while (done_seen == 0) begin
      last_wr = wr_valid;
      @(posedge clk);
      #1;
      if (done) begin
        done_seen = 1;
        check_true(last_wr, "done_o did not come one cycle after the last write");
        check_value("busy_o with done_o", 0, WORD_W'(busy));
        check_value("write count", WORD_W'(cfg.blocks) * BLOCK_WORDS, WORD_W'(wr_count));
      end else begin
        check_value("busy_o while working", 1, WORD_W'(busy));
      end
    end
    // Single pulse and no late writes
    repeat (3) begin
      @(posedge clk);
      #1;
      check_value("done_o after the pulse", 0, WORD_W'(done));
    end
    check_value("final write count", WORD_W'(cfg.blocks) * BLOCK_WORDS, WORD_W'(wr_count));
    for (int b = 0; b < int'(cfg.blocks); b++) begin
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        pt[WORD_W*i +: WORD_W] = mem[cfg.src + ADDR_W'(BLOCK_WORDS*b + i)];
      end
      exp = transform(pt, cfg.key);
      for (int i = 0; i < BLOCK_WORDS; i++) begin
        check_value($sformatf("block %0d word %0d", b, i), exp[WORD_W*i +: WORD_W],
                    mem[cfg.dst + ADDR_W'(BLOCK_WORDS*b + i)]);
      end
    end
  endtask

  initial begin : main_seq
    reset_n    = 1'b0;
    start      = 1'b0;
    src_addr   = '0;
    dst_addr   = '0;
    num_blocks = '0;
    key        = '0;
    rd_valid   = 1'b0;
    rd_data    = '0;
    wr_credit  = 1'b0;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a] = {ADDR_W'(a) ^ 16'hc3a5, ~ADDR_W'(a)};
    end
    limit_cycles = 200;
    add_job("single_block", 128'h0f0e0d0c_0b0a0908_07060504_03020100, 1,
            16'h0100, 16'h0800, 1'b0);
    add_job("multi_block", 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c, 6,
            16'h0200, 16'h0900, 1'b0);
    add_job("slow_credits", 128'h00112233_44556677_8899aabb_ccddeeff, 5,
            16'h0300, 16'h0a00, 1'b1);
    add_job("back_to_back_a", 128'h13579bdf_2468ace0_fdb97531_0eca8642, 2,
            16'h0400, 16'h0b00, 1'b0);
    add_job("back_to_back_b", 128'h5a5a0ff0_c3c33cc3_96966969_a5a5f00f, 3,
            16'h0400, 16'h0c00, 1'b0);
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    cur_name = "reset";
    @(posedge clk);
    #1;
    check_value("done_o", 0, WORD_W'(done));
    check_value("busy_o", 0, WORD_W'(busy));
    check_value("rd_req_o", 0, WORD_W'(rd_req));
    check_value("wr_valid_o", 0, WORD_W'(wr_valid));
    foreach (jobs[j]) begin
      run_job(j);
    end
    $display("Finished %0d jobs: %0d checks, %0d errors", jobs.size(), check_count,
             error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (limit_cycles > 200);
    while (cycles < limit_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the jobs did not finish within %0d cycles", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== accel_top.f ====
hw/accel_pkg.sv
hw/block_stream_if.sv
hw/accel_fsm.sv
hw/plaintext_source.sv
hw/round_key_gen.sv
hw/round_engine.sv
hw/ciphertext_sink.sv
hw/accel_top.sv
verification/accel_tb.sv

// ==== Makefile ====
# Verilator build and run of the accelerator testbench

VERILATOR ?= verilator
TOP       ?= accel_tb
FILELIST  ?= accel_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
